//--- compile.f
+incdir+source
source/pong_pkg.sv
source/frame_tick.sv
source/sprite_sequencer.sv
source/ball_motion.sv
source/paddle_motion.sv
source/pong_top.sv
test/pong_asserts.sv
test/pong_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the pong testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		-f compile.f --top-module pong_tb -Mdir obj_dir -o pong_sim
	./obj_dir/pong_sim | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- test/pong_tb.sv
`timescale 1ns/1ns
`include "pong_settings.svh"

module pong_tb import pong_pkg::*; ();

	localparam int FRAME_PLOTS = 64;
	localparam int SPRITE_PLOTS = 16;
	localparam int TIMEOUT = 2 * `FRAME_CYCLES + 10;
	localparam int MAIN_FRAMES = 300; // Ball x needs 262 steps to touch both sides
	localparam int LEFT_RUN_END = 80;
	localparam int RIGHT_RUN_END = 260;
	localparam int BALL_MAX_X = `SCREEN_W - `BALL_SIZE;
	localparam int BALL_MAX_Y = `SCREEN_H - `BALL_SIZE;
	localparam int PADDLE_MAX_X = `SCREEN_W - `PADDLE_W;

	logic clk;
	logic resetn;
	logic left;
	logic right;
	logic plot;
	pixel_t pixel;

	int cycle = 0;
	int frame_start;
	int release_cycle;
	int value_errors;
	int timeouts;
	int other_errors;
	bit aborted;
	logic [31:0] lcg_state;

	// Reference game state
	int ball_x;
	int ball_y;
	bit ball_x_up;
	bit ball_y_up;
	int pad_x;
	bit btn_left;
	bit btn_right;
	pixel_t exp_pix [FRAME_PLOTS];

	bit hit_x_min;
	bit hit_x_max;
	bit hit_y_min;
	bit hit_y_max;
	bit stuck_min;
	bit stuck_max;
	bit saw_both;
	bit saw_none;

	pong_top pong_top_inst (
		.clk(clk),
		.resetn(resetn),
		.left(left),
		.right(right),
		.plot(plot),
		.pixel(pixel)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic void reset_model();
		ball_x = `BALL_X0;
		ball_y = `BALL_Y0;
		ball_x_up = 1'b1;
		ball_y_up = 1'b1;
		pad_x = `PADDLE_X0;
	endfunction

	// One axis of the ball, reversing at either end
	function automatic void bounce_step(inout int coord, inout bit up, input int limit);
		if (up && coord == limit)
			up = 1'b0;
		else if (!up && coord == 0)
			up = 1'b1;
		coord = up ? coord + 1 : coord - 1;
	endfunction

	function automatic void step_ball();
		bounce_step(ball_x, ball_x_up, BALL_MAX_X);
		bounce_step(ball_y, ball_y_up, BALL_MAX_Y);
		if (ball_x == 0) hit_x_min = 1'b1;
		if (ball_x == BALL_MAX_X) hit_x_max = 1'b1;
		if (ball_y == 0) hit_y_min = 1'b1;
		if (ball_y == BALL_MAX_Y) hit_y_max = 1'b1;
	endfunction

	function automatic void step_paddle();
		if (btn_right && !btn_left) begin
			if (pad_x == PADDLE_MAX_X)
				stuck_max = 1'b1;
			else
				pad_x++;
		end else if (btn_left && !btn_right) begin
			if (pad_x == 0)
				stuck_min = 1'b1;
			else
				pad_x--;
		end
	endfunction

	// Row-major with x fastest
	function automatic void add_rect(input int base, input int x0, input int y0,
			input int w, input int h, input colour_t colour);
		int idx;
		idx = base;
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				exp_pix[idx] = '{x: coord_x_t'(x0 + c), y: coord_y_t'(y0 + r), colour: colour};
				idx++;
			end
		end
	endfunction

	function automatic void build_frame();
		add_rect(0, ball_x, ball_y, `BALL_SIZE, `BALL_SIZE, colour_t'(`COLOUR_OFF));
		step_ball();
		add_rect(16, ball_x, ball_y, `BALL_SIZE, `BALL_SIZE, colour_t'(`COLOUR_ON));
		add_rect(32, pad_x, `PADDLE_Y, `PADDLE_W, 1, colour_t'(`COLOUR_OFF));
		step_paddle();
		add_rect(48, pad_x, `PADDLE_Y, `PADDLE_W, 1, colour_t'(`COLOUR_ON));
	endfunction

	// Long runs left, then right, then mostly random
	task automatic choose_buttons(input int frame);
		logic [15:0] r;
		logic [1:0] pick; // Bit 0 left, bit 1 right
		r = next_rand();
		if (frame < LEFT_RUN_END)
			pick = 2'b01;
		else
			pick = 2'b10;
		if (r[2:0] == 3'd0 || frame >= RIGHT_RUN_END)
			pick = r[9:8];
		if (pick == 2'b11) saw_both = 1'b1;
		if (pick == 2'b00) saw_none = 1'b1;
		btn_left = pick[0];
		btn_right = pick[1];
		@(posedge clk);
		#1;
		left = pick[0];
		right = pick[1];
	endtask

	task automatic wait_plot();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!plot && !aborted) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("Timeout: no plot within %0d cycles at %0t", TIMEOUT, $time);
				timeouts++;
				aborted = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
	endtask

	task automatic run_frame(input int n_plots, input bit after_reset);
		int start_cycle;
		start_cycle = 0;
		build_frame();
		for (int i = 0; i < n_plots; i++) begin
			wait_plot();
			if (aborted) break;
			if (i == 0) begin
				if (after_reset && cycle - release_cycle < `FRAME_CYCLES) begin
					other_errors++;
					$display("First plot came %0d cycles after reset, expected at least %0d",
						cycle - release_cycle, `FRAME_CYCLES);
				end else if (!after_reset && cycle - frame_start != `FRAME_CYCLES) begin
					other_errors++;
					$display("Frame began %0d cycles after the previous one, expected %0d",
						cycle - frame_start, `FRAME_CYCLES);
				end
				frame_start = cycle;
				start_cycle = cycle;
			end else if (cycle - start_cycle != i + i / SPRITE_PLOTS) begin
				// One idle cycle per step and per turn handover
				other_errors++;
				$display("Plot %0d came %0d cycles into the frame, expected %0d",
					i, cycle - start_cycle, i + i / SPRITE_PLOTS);
			end
			if (pixel !== exp_pix[i]) begin
				value_errors++;
				$display("** Error pixel: expected %h, got %h (plot %0d of frame)",
					exp_pix[i], pixel, i);
			end
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		resetn = 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			if (plot !== 1'b0) begin
				value_errors++;
				$display("** Error plot: expected 0, got %h during reset", plot);
			end
		end
		@(posedge clk);
		#1;
		resetn = 1'b1;
		release_cycle = cycle;
		reset_model();
	endtask

	task automatic require_seen(input bit cond, input string what);
		if (!cond) begin
			other_errors++;
			$display("Coverage gap: %s never happened", what);
		end
	endtask

	initial begin
		resetn = 1'b0;
		left = 1'b0;
		right = 1'b0;
		lcg_state = 32'd73;
		value_errors = 0;
		timeouts = 0;
		other_errors = 0;
		aborted = 1'b0;
		frame_start = 0;
		apply_reset();
		for (int f = 0; f < MAIN_FRAMES && !aborted; f++) begin
			choose_buttons(f);
			run_frame(FRAME_PLOTS, f == 0);
		end
		if (!aborted) begin
			require_seen(hit_x_min, "ball at left edge");
			require_seen(hit_x_max, "ball at right edge");
			require_seen(hit_y_min, "ball at top edge");
			require_seen(hit_y_max, "ball at bottom edge");
			require_seen(stuck_min, "paddle held at column 0");
			require_seen(stuck_max, "paddle held at right limit");
			require_seen(saw_both, "both buttons pressed");
			require_seen(saw_none, "no button pressed");
			// Stop partway into the ball draw
			choose_buttons(MAIN_FRAMES);
			run_frame(20, 1'b0);
		end
		if (!aborted) begin
			apply_reset();
			for (int f = 0; f < 5 && !aborted; f++) begin
				choose_buttons(MAIN_FRAMES + 1 + f);
				run_frame(FRAME_PLOTS, f == 0);
			end
		end
		$display("Errors: %0d value, %0d timeout, %0d other", value_errors, timeouts,
			other_errors);
		if (value_errors + timeouts + other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- test/pong_asserts.sv
`timescale 1ns/1ns
`include "pong_settings.svh"

module pong_asserts import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic ball_plot,
	input logic paddle_plot,
	input logic plot,
	input pixel_t pixel
);

	// Turn controller keeps the sequencers apart
	no_overlap: assert property (@(posedge clk) disable iff (!resetn)
		!(ball_plot && paddle_plot))
		else $error("Ball and paddle sequencers plotted in the same cycle");

	x_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (pixel.x < coord_x_t'(`SCREEN_W)))
		else $error("Plotted x %0d is off screen", pixel.x);

	y_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (pixel.y < coord_y_t'(`SCREEN_H)))
		else $error("Plotted y %0d is off screen", pixel.y);

endmodule

bind pong_top pong_asserts pong_asserts_inst (
	.clk(clk),
	.resetn(resetn),
	.ball_plot(ball_plot),
	.paddle_plot(paddle_plot),
	.plot(plot),
	.pixel(pixel)
);

//--- source/pong_top.sv
`timescale 1ns/1ns
`include "pong_settings.svh"

module pong_top import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic left,
	input logic right,
	output logic plot,
	output pixel_t pixel
);

	localparam logic [1:0] T_IDLE = 2'd0;
	localparam logic [1:0] T_BALL = 2'd1;
	localparam logic [1:0] T_PADDLE = 2'd2;

	logic [1:0] turn;
	logic tick;

	logic ball_start;
	logic ball_step;
	logic ball_plot;
	logic ball_done;
	pos_t ball_pos;
	pixel_t ball_pixel;

	logic paddle_start;
	logic paddle_step;
	logic paddle_plot;
	logic paddle_done;
	pos_t paddle_pos;
	pixel_t paddle_pixel;

	frame_tick frame_tick_inst (
		.clk(clk),
		.resetn(resetn),
		.tick(tick)
	);

	// Ticks outside idle are dropped
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			turn <= T_IDLE;
			ball_start <= 1'b0;
			paddle_start <= 1'b0;
		end else begin
			ball_start <= 1'b0;
			paddle_start <= 1'b0;
			case (turn)
				T_IDLE: begin
					if (tick) begin
						turn <= T_BALL;
						ball_start <= 1'b1;
					end
				end
				T_BALL: begin
					if (ball_done) begin
						turn <= T_PADDLE;
						paddle_start <= 1'b1; // Paddle turn right after the ball
					end
				end
				T_PADDLE: if (paddle_done) turn <= T_IDLE;
				default: turn <= T_IDLE;
			endcase
		end
	end

	sprite_sequencer #(
		.SPRITE_W(`BALL_SIZE),
		.SPRITE_H(`BALL_SIZE)
	) ball_seq (
		.clk(clk),
		.resetn(resetn),
		.start(ball_start),
		.pos(ball_pos),
		.step(ball_step),
		.plot(ball_plot),
		.done(ball_done),
		.pixel(ball_pixel)
	);

	ball_motion ball_motion_inst (
		.clk(clk),
		.resetn(resetn),
		.step(ball_step),
		.pos(ball_pos)
	);

	sprite_sequencer #(
		.SPRITE_W(`PADDLE_W),
		.SPRITE_H(1)
	) paddle_seq (
		.clk(clk),
		.resetn(resetn),
		.start(paddle_start),
		.pos(paddle_pos),
		.step(paddle_step),
		.plot(paddle_plot),
		.done(paddle_done),
		.pixel(paddle_pixel)
	);

	paddle_motion paddle_motion_inst (
		.clk(clk),
		.resetn(resetn),
		.step(paddle_step),
		.left(left),
		.right(right),
		.pos(paddle_pos)
	);

	// Busy sequencer owns the plot port
	assign plot = (turn == T_PADDLE) ? paddle_plot : ball_plot;
	assign pixel = (turn == T_PADDLE) ? paddle_pixel : ball_pixel;

endmodule

//--- source/paddle_motion.sv
`timescale 1ns/1ns
`include "pong_settings.svh"

module paddle_motion import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic step,
	input logic left,
	input logic right,
	output pos_t pos
);

	localparam coord_x_t MAX_X = coord_x_t'(`SCREEN_W - `PADDLE_W);

	coord_x_t col;

	// Buttons sampled only on the step pulse
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			col <= coord_x_t'(`PADDLE_X0);
		end else if (step) begin
			if (right && !left && col != MAX_X)
				col <= col + 1'b1;
			else if (left && !right && col != '0)
				col <= col - 1'b1;
		end
	end

	// Row never changes
	assign pos = '{
		x: col,
		y: coord_y_t'(`PADDLE_Y)
	};

endmodule

//--- source/ball_motion.sv
`timescale 1ns/1ns
`include "pong_settings.svh"

module ball_motion import pong_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic step,
	output pos_t pos
);

	localparam coord_x_t MAX_X = coord_x_t'(`SCREEN_W - `BALL_SIZE);
	localparam coord_y_t MAX_Y = coord_y_t'(`SCREEN_H - `BALL_SIZE);

	logic x_up; // Moving toward larger x
	logic y_up;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			pos.x <= coord_x_t'(`BALL_X0);
			x_up <= 1'b1;
		end else if (step) begin
			if (x_up && pos.x == MAX_X) begin
				x_up <= 1'b0; // Bounce off right edge
				pos.x <= pos.x - 1'b1;
			end else if (!x_up && pos.x == '0) begin
				x_up <= 1'b1;
				pos.x <= pos.x + 1'b1;
			end else begin
				pos.x <= x_up ? pos.x + 1'b1 : pos.x - 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			pos.y <= coord_y_t'(`BALL_Y0);
			y_up <= 1'b1;
		end else if (step) begin
			if (y_up && pos.y == MAX_Y) begin
				y_up <= 1'b0; // Bounce off bottom edge
				pos.y <= pos.y - 1'b1;
			end else if (!y_up && pos.y == '0) begin
				y_up <= 1'b1;
				pos.y <= pos.y + 1'b1;
			end else begin
				pos.y <= y_up ? pos.y + 1'b1 : pos.y - 1'b1;
			end
		end
	end

endmodule

//--- source/sprite_sequencer.sv
`timescale 1ns/1ns
`include "pong_settings.svh"

module sprite_sequencer import pong_pkg::*; #(
	parameter int SPRITE_W = 4,
	parameter int SPRITE_H = 4
) (
	input logic clk,
	input logic resetn,
	input logic start,
	input pos_t pos,
	output logic step,
	output logic plot,
	output logic done,
	output pixel_t pixel
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ERASE = 2'd1;
	localparam logic [1:0] S_STEP = 2'd2;
	localparam logic [1:0] S_DRAW = 2'd3;

	// One bit minimum so a single-row sprite still has a row counter
	localparam int COL_BITS = (SPRITE_W > 1) ? $clog2(SPRITE_W) : 1;
	localparam int ROW_BITS = (SPRITE_H > 1) ? $clog2(SPRITE_H) : 1;

	logic [1:0] state;
	logic [COL_BITS-1:0] col;
	logic [ROW_BITS-1:0] row;
	logic last_col;
	logic last_pix;

	assign last_col = (col == COL_BITS'(SPRITE_W - 1));
	assign last_pix = last_col && (row == ROW_BITS'(SPRITE_H - 1));

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (start) state <= S_ERASE;
				S_ERASE: if (last_pix) state <= S_STEP;
				S_STEP: state <= S_DRAW; // Motion module updates pos here
				S_DRAW: if (last_pix) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Row-major scan, x fastest, wraps to zero after the last pixel
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			col <= '0;
			row <= '0;
		end else if (plot) begin
			if (last_col) begin
				col <= '0;
				row <= last_pix ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assign plot = (state == S_ERASE) || (state == S_DRAW);
	assign step = (state == S_STEP);
	assign done = (state == S_DRAW) && last_pix; // With the last draw plot

	// Pixel is the corner plus the scan offsets
	assign pixel = '{
		x: pos.x + coord_x_t'(col),
		y: pos.y + coord_y_t'(row),
		colour: (state == S_DRAW) ? colour_t'(`COLOUR_ON) : colour_t'(`COLOUR_OFF)
	};

endmodule

//--- source/frame_tick.sv
`timescale 1ns/1ns
`include "pong_settings.svh"

module frame_tick (
	input logic clk,
	input logic resetn,
	output logic tick
);

	localparam int CNT_BITS = $clog2(`FRAME_CYCLES);

	logic [CNT_BITS-1:0] count;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			count <= CNT_BITS'(`FRAME_CYCLES - 1);
			tick <= 1'b0;
		end else if (count == '0) begin
			count <= CNT_BITS'(`FRAME_CYCLES - 1); // Reload for the next frame
			tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

//--- source/pong_pkg.sv
`include "pong_settings.svh"

package pong_pkg;

	typedef logic [`X_BITS-1:0] coord_x_t;
	typedef logic [`Y_BITS-1:0] coord_y_t;
	typedef logic [`COLOUR_BITS-1:0] colour_t;

	// Top-left corner of a sprite
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} pos_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} pixel_t;

endpackage

//--- source/pong_settings.svh
`ifndef PONG_SETTINGS_SVH
`define PONG_SETTINGS_SVH

// Display size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

`define X_BITS 8
`define Y_BITS 7
`define COLOUR_BITS 3

`define BALL_SIZE 4 // Square ball side
`define PADDLE_W 16
`define PADDLE_Y 119 // Bottom row

// Start positions after reset
`define BALL_X0 50
`define BALL_Y0 60
`define PADDLE_X0 50

`define FRAME_CYCLES 100 // Must exceed the busy cycles of one frame
`define COLOUR_ON 7 // White
`define COLOUR_OFF 0 // Black

`endif
